// File: rtl/core_glue_pkg.sv
// core glue shared definitions
// bridge address windows, video and button bundles, data-table constants

`default_nettype none

package core_glue_pkg;

  // 32-bit bridge data / address word
  typedef logic [31:0] bridge_word_t;

  // address window of a bridge access
  typedef enum logic [1:0] {
    region_save,
    region_cmd,
    region_none
  } bridge_region_t;

  // save window, upper nibble 2
  localparam logic [3:0] save_region_nibble = 4'h2;
  // command handler window, upper byte f8
  localparam logic [7:0] cmd_region_byte = 8'hf8;

  //////////////////////////////
  // video bundles

  // raw video from the core
  typedef struct packed {
    logic        hblank;
    logic        vblank;
    logic        hsync;
    logic        vsync;
    logic [23:0] rgb;
  } video_in_t;

  // registered video toward the scaler
  typedef struct packed {
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } video_out_t;

  //////////////////////////////
  // controllers

  // raw key bitmap, l2/r2/l3/r3 at 10..13 stay unmapped
  typedef logic [15:0] key_word_t;

  localparam int key_up_bit     = 0;
  localparam int key_down_bit   = 1;
  localparam int key_left_bit   = 2;
  localparam int key_right_bit  = 3;
  localparam int key_a_bit      = 4;
  localparam int key_b_bit      = 5;
  localparam int key_x_bit      = 6;
  localparam int key_y_bit      = 7;
  localparam int key_l_bit      = 8;
  localparam int key_r_bit      = 9;
  localparam int key_select_bit = 14;
  localparam int key_start_bit  = 15;

  // named buttons for one player
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic a;
    logic b;
    logic x;
    logic y;
    logic l;
    logic r;
    logic select;
    logic start;
  } pad_buttons_t;

  //////////////////////////////
  // data table

  // save size for size code 1, doubles per code step
  localparam bridge_word_t save_size_base = 32'd1024;

endpackage

`default_nettype wire

// File: rtl/bridge_read_mux.sv
// bridge read data select
// save window first, then command window, zero elsewhere

`timescale 1ns/1ns
`default_nettype none

module bridge_read_mux import core_glue_pkg::*; (
  input  bridge_word_t bridge_addr,
  input  bridge_word_t cmd_rd_data,
  input  bridge_word_t save_rd_data,
  output bridge_word_t bridge_rd_data
);

  bridge_region_t region;

  // address decode
  // save window wins when both match
  always_comb begin
    if (bridge_addr[31:28] == save_region_nibble) begin
      region = region_save;
    end else if (bridge_addr[31:24] == cmd_region_byte) begin
      region = region_cmd;
    end else begin
      region = region_none;
    end
  end

  // word select per region
  always_comb begin
    case (region)
      region_save: bridge_rd_data = save_rd_data;
      region_cmd:  bridge_rd_data = cmd_rd_data;
      default:     bridge_rd_data = '0;
    endcase
  end

  // decode never produces the spare encoding
  always_comb begin
    region_legal_a: assert (region inside {region_save, region_cmd, region_none})
      else $error("bridge region out of range: %0h", region);
  end

endmodule

`default_nettype wire

// File: rtl/slot_transfer_flags.sv
// data-slot transfer flags
// ioctl_download tracks a rom write transfer,
// save_download any save read or write transfer

`timescale 1ns/1ns
`default_nettype none

module slot_transfer_flags (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic dataslot_requestread,
  input  logic dataslot_requestwrite,
  input  logic dataslot_allcomplete,
  output logic ioctl_download,
  output logic save_download
);

  // previous allcomplete, for edge detect
  logic allcomplete_prev;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_prev <= 1'b0;
      ioctl_download   <= 1'b0;
      save_download    <= 1'b0;
    end else begin
      allcomplete_prev <= dataslot_allcomplete;

      // rom flag, set wins over clear
      if (dataslot_requestwrite) begin
        ioctl_download <= 1'b1;
      end else if (dataslot_allcomplete) begin
        ioctl_download <= 1'b0;
      end

      // save flag clears only on the allcomplete edge
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (dataslot_allcomplete && !allcomplete_prev) begin
        save_download <= 1'b0;
      end
    end
  end

  // rom flag only ever rises after a write request
  ioctl_rise_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(ioctl_download) |-> $past(dataslot_requestwrite))
    else $error("ioctl_download rose without requestwrite");

endmodule

`default_nettype wire

// File: rtl/datatable_sequencer.sv
// data-table sequencer
// eight-phase cycle on the shared table port:
// phases 5..7 write the save size, phases 0..4 read the rom entry,
// rom size sampled in phase 4

`timescale 1ns/1ns
`default_nettype none

module datatable_sequencer import core_glue_pkg::*; #(
  parameter int SAVE_SLOT = 1,
  parameter int ROM_SLOT  = 0
) (
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  input  logic [3:0]   sram_size,
  input  bridge_word_t datatable_q,
  output logic [9:0]   datatable_addr,
  output logic         datatable_wren,
  output bridge_word_t datatable_data,
  output bridge_word_t rom_file_size
);

  // table entries hold the size word at index 2*slot+1
  localparam logic [9:0] save_entry = 10'(2 * SAVE_SLOT + 1);
  localparam logic [9:0] rom_entry  = 10'(2 * ROM_SLOT + 1);

  // phase boundaries
  localparam logic [2:0] rom_sample_phase = 3'd4;
  localparam logic [2:0] last_read_phase  = 3'd4;

  // free running, wraps every 8
  logic [2:0]   phase;
  // save size from the size code, 0 means no save ram
  bridge_word_t save_size;

  always_comb begin
    if (sram_size != 4'd0) begin
      save_size = save_size_base << (sram_size - 4'd1);
    end else begin
      save_size = '0;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase          <= 3'd0;
      datatable_addr <= '0;
      datatable_wren <= 1'b0;
      datatable_data <= '0;
      rom_file_size  <= '0;
    end else begin
      phase <= phase + 3'd1;

      if (phase > last_read_phase) begin
        // write slot
        datatable_wren <= 1'b1;
        datatable_addr <= save_entry;
        datatable_data <= save_size;
      end else begin
        // read slot, q of the rom entry comes back meanwhile
        datatable_wren <= 1'b0;
        datatable_addr <= rom_entry;
        if (phase == rom_sample_phase) begin
          rom_file_size <= datatable_q;
        end
      end
    end
  end

  // writes only ever target the save entry
  wren_addr_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable_wren |-> (datatable_addr == save_entry))
    else $error("datatable write to %0h, expected %0h", datatable_addr, save_entry);

endmodule

`default_nettype wire

// File: rtl/video_output_stage.sv
// video output stage
// data-enable and rgb gated by blanking,
// sync levels turned into one-cycle pulses, one cycle latency

`timescale 1ns/1ns
`default_nettype none

module video_output_stage import core_glue_pkg::*; (
  input  logic       clk_74a,
  input  logic       pll_core_locked,
  input  video_in_t  video_in,
  output video_out_t video_out
);

  // last sync levels for edge detect
  logic hs_prev;
  logic vs_prev;
  // active picture
  logic active;

  assign active = !(video_in.hblank || video_in.vblank);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_out <= '0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_out.de <= active;
      // black outside the active area
      video_out.rgb <= active ? video_in.rgb : 24'h0;

      // pulse on rising sync edges
      video_out.hs <= video_in.hsync && !hs_prev;
      video_out.vs <= video_in.vsync && !vs_prev;
      hs_prev      <= video_in.hsync;
      vs_prev      <= video_in.vsync;
    end
  end

  // sync pulses never last two cycles
  hs_pulse_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.hs |=> !video_out.hs)
    else $error("video_out.hs high two cycles");

  vs_pulse_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_out.vs |=> !video_out.vs)
    else $error("video_out.vs high two cycles");

endmodule

`default_nettype wire

// File: rtl/controller_sync.sv
// controller synchronizer for one player
// three flops on the raw key word, then bits mapped to named buttons

`timescale 1ns/1ns
`default_nettype none

module controller_sync import core_glue_pkg::*; (
  input  logic         clk_74a,
  input  logic         pll_core_locked,
  input  key_word_t    cont_key,
  output pad_buttons_t pad
);

  // synchronizer chain
  key_word_t key_s1;
  key_word_t key_s2;
  key_word_t key_s3;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      key_s1 <= '0;
      key_s2 <= '0;
      key_s3 <= '0;
    end else begin
      key_s1 <= cont_key;
      key_s2 <= key_s1;
      key_s3 <= key_s2;
    end
  end

  // bit map, pure wiring off the last stage
  always_comb begin
    pad.up     = key_s3[key_up_bit];
    pad.down   = key_s3[key_down_bit];
    pad.left   = key_s3[key_left_bit];
    pad.right  = key_s3[key_right_bit];
    pad.a      = key_s3[key_a_bit];
    pad.b      = key_s3[key_b_bit];
    pad.x      = key_s3[key_x_bit];
    pad.y      = key_s3[key_y_bit];
    pad.l      = key_s3[key_l_bit];
    pad.r      = key_s3[key_r_bit];
    pad.select = key_s3[key_select_bit];
    pad.start  = key_s3[key_start_bit];
  end

endmodule

`default_nettype wire

// File: rtl/core_glue_top.sv
// core glue top level
// bridge read mux, data-slot flags, data-table sequencer,
// video output stage and two controller synchronizers, all on clk_74a

`timescale 1ns/1ns
`default_nettype none

module core_glue_top import core_glue_pkg::*; #(
  parameter int SAVE_SLOT = 1,
  parameter int ROM_SLOT  = 0
) (
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  // bridge
  input  bridge_word_t bridge_addr,
  input  bridge_word_t cmd_rd_data,
  input  bridge_word_t save_rd_data,
  output bridge_word_t bridge_rd_data,

  // data slots
  input  logic         dataslot_requestread,
  input  logic         dataslot_requestwrite,
  input  logic         dataslot_allcomplete,
  output logic         ioctl_download,
  output logic         save_download,

  // data table
  input  logic [3:0]   sram_size,
  input  bridge_word_t datatable_q,
  output logic [9:0]   datatable_addr,
  output logic         datatable_wren,
  output bridge_word_t datatable_data,
  output bridge_word_t rom_file_size,

  // video
  input  video_in_t    video_in,
  output video_out_t   video_out,

  // controllers
  input  key_word_t    cont1_key,
  input  key_word_t    cont2_key,
  output pad_buttons_t p1_pad,
  output pad_buttons_t p2_pad
);

  //////////////////////////////
  // bridge side

  // read word select, combinational
  bridge_read_mux u_read_mux (
    .bridge_addr    (bridge_addr),
    .cmd_rd_data    (cmd_rd_data),
    .save_rd_data   (save_rd_data),
    .bridge_rd_data (bridge_rd_data)
  );

  // rom / save transfer flags
  slot_transfer_flags u_slot_flags (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .ioctl_download        (ioctl_download),
    .save_download         (save_download)
  );

  // save size write and rom size read on the shared table port
  datatable_sequencer #(
    .SAVE_SLOT (SAVE_SLOT),
    .ROM_SLOT  (ROM_SLOT)
  ) u_datatable (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .sram_size       (sram_size),
    .datatable_q     (datatable_q),
    .datatable_addr  (datatable_addr),
    .datatable_wren  (datatable_wren),
    .datatable_data  (datatable_data),
    .rom_file_size   (rom_file_size)
  );

  //////////////////////////////
  // core side

  video_output_stage u_video (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .video_in        (video_in),
    .video_out       (video_out)
  );

  // one synchronizer per player
  controller_sync u_p1_sync (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .cont_key        (cont1_key),
    .pad             (p1_pad)
  );

  controller_sync u_p2_sync (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .cont_key        (cont2_key),
    .pad             (p2_pad)
  );

endmodule

`default_nettype wire

// File: verif/tb_core_glue.sv
// testbench for the core glue top level
// lfsr stimulus on the falling clock edge, concurrent assertions
// against a reference model built from the block rules

`timescale 1ns/1ns
`default_nettype none

module tb_core_glue import core_glue_pkg::*; ();

  localparam int clk_period   = 100;
  localparam int reset_cycles = 16;
  localparam int test_cycles  = 300;
  localparam int num_tests    = 5;
  localparam int watchdog_ns  = (num_tests * test_cycles + reset_cycles + 100) * clk_period;
  localparam logic [31:0] lfsr_seed = 32'd83408;
  // default slots 1 and 0 give table entries 3 and 1
  localparam logic [9:0] save_entry_exp = 10'd3;
  localparam logic [9:0] rom_entry_exp  = 10'd1;

  logic         clk_74a;
  logic         pll_core_locked;
  bridge_word_t bridge_addr;
  bridge_word_t cmd_rd_data;
  bridge_word_t save_rd_data;
  bridge_word_t bridge_rd_data;
  logic         dataslot_requestread;
  logic         dataslot_requestwrite;
  logic         dataslot_allcomplete;
  logic         ioctl_download;
  logic         save_download;
  logic [3:0]   sram_size;
  bridge_word_t datatable_q;
  logic [9:0]   datatable_addr;
  logic         datatable_wren;
  bridge_word_t datatable_data;
  bridge_word_t rom_file_size;
  video_in_t    video_in;
  video_out_t   video_out;
  key_word_t    cont1_key;
  key_word_t    cont2_key;
  pad_buttons_t p1_pad;
  pad_buttons_t p2_pad;

  logic [31:0]  lfsr_state;
  int           err_count;

  core_glue_top i_dut (
    .clk_74a               (clk_74a),
    .pll_core_locked       (pll_core_locked),
    .bridge_addr           (bridge_addr),
    .cmd_rd_data           (cmd_rd_data),
    .save_rd_data          (save_rd_data),
    .bridge_rd_data        (bridge_rd_data),
    .dataslot_requestread  (dataslot_requestread),
    .dataslot_requestwrite (dataslot_requestwrite),
    .dataslot_allcomplete  (dataslot_allcomplete),
    .ioctl_download        (ioctl_download),
    .save_download         (save_download),
    .sram_size             (sram_size),
    .datatable_q           (datatable_q),
    .datatable_addr        (datatable_addr),
    .datatable_wren        (datatable_wren),
    .datatable_data        (datatable_data),
    .rom_file_size         (rom_file_size),
    .video_in              (video_in),
    .video_out             (video_out),
    .cont1_key             (cont1_key),
    .cont2_key             (cont2_key),
    .p1_pad                (p1_pad),
    .p2_pad                (p2_pad)
  );

  initial begin
    clk_74a = 1'b0;
    forever #(clk_period / 2) clk_74a = ~clk_74a;
  end

  //////////////////////////////
  // helpers

  // 32-bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // size code 0 means no save ram, else 1k doubled per step
  function automatic bridge_word_t save_size_for(input logic [3:0] code);
    if (code == 4'd0) begin
      return '0;
    end
    return save_size_base << (code - 4'd1);
  endfunction

  function automatic pad_buttons_t map_keys(input key_word_t k);
    pad_buttons_t p;
    p.up     = k[key_up_bit];
    p.down   = k[key_down_bit];
    p.left   = k[key_left_bit];
    p.right  = k[key_right_bit];
    p.a      = k[key_a_bit];
    p.b      = k[key_b_bit];
    p.x      = k[key_x_bit];
    p.y      = k[key_y_bit];
    p.l      = k[key_l_bit];
    p.r      = k[key_r_bit];
    p.select = k[key_select_bit];
    p.start  = k[key_start_bit];
    return p;
  endfunction

  // strobe density per test, in and-ed random bits
  function automatic int test_density(input int t);
    case (t)
      0:       return 1;
      1:       return 3;
      2:       return 2;
      3:       return 4;
      default: return 1;
    endcase
  endfunction

  function automatic string test_name(input int t);
    case (t)
      0:       return "dense strobes";
      1:       return "sparse strobes";
      2:       return "mixed strobes";
      3:       return "rare strobes";
      default: return "dense strobes again";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("[FAIL] %s got %0h expected %0h at %0t", name, got, expected, $time);
    err_count++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    err_count++;
  endtask

  //////////////////////////////
  // reference model

  logic [2:0]   tb_phase;
  logic [2:0]   phase_d1;
  logic [3:0]   sram_d1;
  logic [2:0]   settle_cnt;
  logic         settled;
  logic         ac_prev;
  logic         exp_ioctl;
  logic         exp_save;
  bridge_word_t exp_rom_size;
  bridge_word_t exp_rd_data;
  logic         exp_wren;
  logic [9:0]   exp_addr;
  bridge_word_t exp_save_size;
  video_in_t    vid_d1;
  video_in_t    vid_d2;
  logic         exp_de;
  logic [23:0]  exp_rgb;
  logic         exp_hs;
  logic         exp_vs;
  key_word_t    key1_d1;
  key_word_t    key1_d2;
  key_word_t    key1_d3;
  key_word_t    key2_d1;
  key_word_t    key2_d2;
  key_word_t    key2_d3;
  pad_buttons_t exp_p1;
  pad_buttons_t exp_p2;

  // region rule, save window first
  always_comb begin
    if (bridge_addr[31:28] == 4'h2) begin
      exp_rd_data = save_rd_data;
    end else if (bridge_addr[31:24] == 8'hf8) begin
      exp_rd_data = cmd_rd_data;
    end else begin
      exp_rd_data = '0;
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      tb_phase     <= 3'd0;
      settle_cnt   <= 3'd0;
      ac_prev      <= 1'b0;
      exp_ioctl    <= 1'b0;
      exp_save     <= 1'b0;
      exp_rom_size <= '0;
    end else begin
      tb_phase <= tb_phase + 3'd1;
      if (settle_cnt != 3'd3) begin
        settle_cnt <= settle_cnt + 3'd1;
      end
      ac_prev <= dataslot_allcomplete;
      // set wins over clear on both flags
      if (dataslot_requestwrite) begin
        exp_ioctl <= 1'b1;
      end else if (dataslot_allcomplete) begin
        exp_ioctl <= 1'b0;
      end
      if (dataslot_requestread || dataslot_requestwrite) begin
        exp_save <= 1'b1;
      end else if (dataslot_allcomplete && !ac_prev) begin
        exp_save <= 1'b0;
      end
      // rom size taken in phase 4
      if (tb_phase == 3'd4) begin
        exp_rom_size <= datatable_q;
      end
    end
  end

  // input history for the latency checks
  always_ff @(posedge clk_74a) begin
    phase_d1 <= tb_phase;
    sram_d1  <= sram_size;
    vid_d1   <= video_in;
    vid_d2   <= vid_d1;
    key1_d1  <= cont1_key;
    key1_d2  <= key1_d1;
    key1_d3  <= key1_d2;
    key2_d1  <= cont2_key;
    key2_d2  <= key2_d1;
    key2_d3  <= key2_d2;
  end

  // history is valid three cycles out of reset
  assign settled       = (settle_cnt == 3'd3);
  assign exp_wren      = (phase_d1 >= 3'd5);
  assign exp_addr      = exp_wren ? save_entry_exp : rom_entry_exp;
  assign exp_save_size = save_size_for(sram_d1);
  assign exp_de        = !(vid_d1.hblank || vid_d1.vblank);
  assign exp_rgb       = exp_de ? vid_d1.rgb : 24'h0;
  assign exp_hs        = vid_d1.hsync && !vid_d2.hsync;
  assign exp_vs        = vid_d1.vsync && !vid_d2.vsync;
  assign exp_p1        = map_keys(key1_d3);
  assign exp_p2        = map_keys(key2_d3);

  //////////////////////////////
  // checks

  rd_data_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_rd_data == exp_rd_data)
    else report_mismatch("bridge_rd_data", $sampled(bridge_rd_data), $sampled(exp_rd_data));

  ioctl_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    ioctl_download == exp_ioctl)
    else report_mismatch("ioctl_download", 32'($sampled(ioctl_download)),
                         32'($sampled(exp_ioctl)));

  save_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    save_download == exp_save)
    else report_mismatch("save_download", 32'($sampled(save_download)),
                         32'($sampled(exp_save)));

  // three of every eight, as phases 5..7
  wren_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settled |-> datatable_wren == exp_wren)
    else report_mismatch("datatable_wren", 32'($sampled(datatable_wren)),
                         32'($sampled(exp_wren)));

  addr_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settled |-> datatable_addr == exp_addr)
    else report_mismatch("datatable_addr", 32'($sampled(datatable_addr)),
                         32'($sampled(exp_addr)));

  data_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (settled && exp_wren) |-> datatable_data == exp_save_size)
    else report_mismatch("datatable_data", $sampled(datatable_data),
                         $sampled(exp_save_size));

  // also covers stability between samples
  rom_size_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    rom_file_size == exp_rom_size)
    else report_mismatch("rom_file_size", $sampled(rom_file_size), $sampled(exp_rom_size));

  de_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settled |-> video_out.de == exp_de)
    else report_mismatch("video_out.de", 32'($sampled(video_out.de)), 32'($sampled(exp_de)));

  rgb_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settled |-> video_out.rgb == exp_rgb)
    else report_mismatch("video_out.rgb", 32'($sampled(video_out.rgb)),
                         32'($sampled(exp_rgb)));

  hs_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settled |-> video_out.hs == exp_hs)
    else report_mismatch("video_out.hs", 32'($sampled(video_out.hs)), 32'($sampled(exp_hs)));

  vs_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settled |-> video_out.vs == exp_vs)
    else report_mismatch("video_out.vs", 32'($sampled(video_out.vs)), 32'($sampled(exp_vs)));

  p1_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settled |-> p1_pad == exp_p1)
    else report_mismatch("p1_pad", 32'($sampled(p1_pad)), 32'($sampled(exp_p1)));

  p2_a: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    settled |-> p2_pad == exp_p2)
    else report_mismatch("p2_pad", 32'($sampled(p2_pad)), 32'($sampled(exp_p2)));

  // first edge out of reset sees cleared outputs
  reset_a: assert property (@(posedge clk_74a) $rose(pll_core_locked) |->
    (!ioctl_download && !save_download && !datatable_wren && !video_out.de &&
     !video_out.hs && !video_out.vs && p1_pad == '0 && p2_pad == '0))
    else report_failure("outputs were not all cleared when reset was released");

  //////////////////////////////
  // stimulus

  // one lfsr step per bit
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // high with probability 1 / 2**density
  task automatic draw_strobe(input int density, output logic strobe);
    logic [31:0] bits;
    draw_bits(density, bits);
    strobe = (bits == ((32'd1 << density) - 32'd1));
  endtask

  task automatic drive_cycle(input int density);
    logic [31:0] bits;
    logic        flip;
    @(negedge clk_74a);
    // aim at save, command or any window
    draw_bits(2, bits);
    case (bits[1:0])
      2'd0: begin
        draw_bits(28, bits);
        bridge_addr = {4'h2, bits[27:0]};
      end
      2'd1: begin
        draw_bits(24, bits);
        bridge_addr = {8'hf8, bits[23:0]};
      end
      default: draw_bits(32, bridge_addr);
    endcase
    draw_bits(32, cmd_rd_data);
    draw_bits(32, save_rd_data);
    draw_strobe(density, dataslot_requestread);
    draw_strobe(density, dataslot_requestwrite);
    draw_strobe(density, dataslot_allcomplete);
    draw_bits(4, bits);
    sram_size = bits[3:0];
    draw_bits(32, datatable_q);
    // video, blanking and sync levels held for a few cycles
    draw_strobe(density, video_in.hblank);
    draw_strobe(density, video_in.vblank);
    draw_strobe(2, flip);
    video_in.hsync = video_in.hsync ^ flip;
    draw_strobe(2, flip);
    video_in.vsync = video_in.vsync ^ flip;
    draw_bits(24, bits);
    video_in.rgb = bits[23:0];
    draw_bits(16, bits);
    cont1_key = bits[15:0];
    draw_bits(16, bits);
    cont2_key = bits[15:0];
  endtask

  //////////////////////////////
  // main sequence and watchdog

  initial begin
    int errs_before;
    lfsr_state            = lfsr_seed;
    err_count             = 0;
    pll_core_locked       = 1'b0;
    bridge_addr           = '0;
    cmd_rd_data           = '0;
    save_rd_data          = '0;
    dataslot_requestread  = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    sram_size             = 4'd0;
    datatable_q           = '0;
    video_in              = '0;
    cont1_key             = '0;
    cont2_key             = '0;
    repeat (reset_cycles) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    for (int t = 0; t < num_tests; t++) begin
      errs_before = err_count;
      repeat (test_cycles) drive_cycle(test_density(t));
      $display("test %0d %s: %0d errors", t, test_name(t), err_count - errs_before);
    end
    // let the last samples reach the checks
    repeat (4) @(negedge clk_74a);
    $display("tests run %0d, total errors %0d", num_tests, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: core_glue_top.f
rtl/core_glue_pkg.sv
rtl/bridge_read_mux.sv
rtl/slot_transfer_flags.sv
rtl/datatable_sequencer.sv
rtl/video_output_stage.sv
rtl/controller_sync.sv
rtl/core_glue_top.sv
verif/tb_core_glue.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the core glue testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_core_glue -f core_glue_top.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "=== PASS ===" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
